//--- build.f
+incdir+rtl
+incdir+verification
rtl/avg_pkg.sv
rtl/gda_adder.sv
rtl/window_stage.sv
rtl/pair_sum_stage.sv
rtl/average_stage.sv
rtl/approx_avg_top.sv
verification/tb_approx_avg.sv

//--- verification/tb_approx_avg_model.svh
`ifndef TB_APPROX_AVG_MODEL_SVH
`define TB_APPROX_AVG_MODEL_SVH

`include "avg_cfg.svh"

// Carry into bit k only sees generate terms up to GDA_WINDOW positions below it
function automatic avg_pkg::pair_sum_t approx_pair_sum(input avg_pkg::sample_t a,
                                                      input avg_pkg::sample_t b);
    logic [7:0]         g;
    logic [7:0]         p;
    logic [7:0]         c;
    logic               chain;
    avg_pkg::pair_sum_t r;
    int                 k;
    int                 j;
    int                 m;
    int                 lo;
    g = a & b;
    p = a ^ b;
    c = '0;
    for (k = 1; k < 8; k++) begin
        lo = (k > `GDA_WINDOW) ? k - `GDA_WINDOW : 0;
        for (j = k - 1; j >= lo; j--) begin
            chain = g[j];
            for (m = j + 1; m < k; m++) begin
                chain = chain & p[m];
            end
            c[k] = c[k] | chain;
        end
    end
    r[7:0] = p ^ c;
    r[8] = g[7] | (p[7] & c[7]);
    return r;
endfunction

// Approximate pair sums, then an exact total divided by four
function automatic avg_pkg::sample_t expected_average(input avg_pkg::sample_t s0,
                                                      input avg_pkg::sample_t s1,
                                                      input avg_pkg::sample_t s2,
                                                      input avg_pkg::sample_t s3);
    avg_pkg::total_t total;
    total = 10'(approx_pair_sum(s0, s1)) + 10'(approx_pair_sum(s2, s3));
    return total[9:2];
endfunction

function automatic avg_pkg::sample_t exact_mean(input avg_pkg::sample_t s0,
                                                input avg_pkg::sample_t s1,
                                                input avg_pkg::sample_t s2,
                                                input avg_pkg::sample_t s3);
    avg_pkg::total_t total;
    total = 10'(s0) + 10'(s1) + 10'(s2) + 10'(s3);
    return total[9:2];
endfunction

`endif

//--- verification/tb_approx_avg.sv
`timescale 1ns/1ps
`include "avg_cfg.svh"

module tb_approx_avg;

    localparam int TIMEOUT_CYCLES = 20;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    avg_pkg::sample_t in_sample;
    logic             out_valid;
    avg_pkg::sample_t out_avg;

    int               value_errors;
    int               valid_errors;
    int               other_errors;
    bit               timed_out;
    int               cycle_cnt;
    int               fill_cnt;
    int               last_accept;
    integer           seed;
    logic             valid_due;
    avg_pkg::sample_t exp_avg;
    avg_pkg::sample_t taps [0:3];
    avg_pkg::sample_t exp_q [$];
    int               due_q [$];
    avg_pkg::sample_t last_model;
    avg_pkg::sample_t last_exact;

    `include "tb_approx_avg_model.svh"

    approx_avg_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .out_valid (out_valid),
        .out_avg   (out_avg)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ********************
    // Compare tasks
    // ********************
    task automatic check_avg(input avg_pkg::sample_t got, input avg_pkg::sample_t exp,
                             input string what);
        if (got !== exp) begin
            value_errors++;
            $display("error %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            valid_errors++;
            $display("error %0t: out_valid got %b expected %b", $time, got, exp);
        end
    endtask

    // Output monitor samples at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            valid_due = (due_q.size() > 0) && (due_q[0] == cycle_cnt);
            check_valid(out_valid, valid_due);
            if (valid_due) begin
                void'(due_q.pop_front());
                exp_avg = exp_q.pop_front();
                if (out_valid === 1'b1) begin
                    check_avg(out_avg, exp_avg, "out_avg");
                end
            end
        end
    end

    // ********************
    // Drivers and waits
    // ********************
    task automatic drive_sample(input avg_pkg::sample_t s);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_sample = s;
        last_accept = cycle_cnt + 1;
        taps[3] = taps[2];
        taps[2] = taps[1];
        taps[1] = taps[0];
        taps[0] = s;
        if (fill_cnt < `AVG_TAPS) begin
            fill_cnt++;
        end
        if (fill_cnt == `AVG_TAPS) begin
            last_model = expected_average(taps[0], taps[1], taps[2], taps[3]);
            last_exact = exact_mean(taps[0], taps[1], taps[2], taps[3]);
            exp_q.push_back(last_model);
            // Two edges of pipeline after the accepting edge
            due_q.push_back(last_accept + 2);
        end
    endtask

    // Idle data is random so a gap that leaks into the window shows up
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
            in_sample = avg_pkg::sample_t'($random(seed));
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                timed_out = 1'b1;
                $display("timeout: %0d expected outputs never appeared", exp_q.size());
            end
        end
    endtask

    task automatic wait_for_out_valid(output int seen_edge);
        int waited;
        waited = 0;
        seen_edge = -1;
        while (seen_edge < 0 && !timed_out) begin
            @(negedge clk);
            if (out_valid === 1'b1) begin
                seen_edge = cycle_cnt;
            end else begin
                waited++;
                if (waited > TIMEOUT_CYCLES) begin
                    timed_out = 1'b1;
                    $display("timeout: out_valid never rose after the fourth sample");
                end
            end
        end
    endtask

    // ********************
    // Directed tests
    // ********************
    task automatic fill_latency();
        int seen;
        idle_cycles(5);
        drive_sample(8'h01);
        drive_sample(8'h02);
        drive_sample(8'h03);
        idle_cycles(4);
        drive_sample(8'h04);
        idle_cycles(1);
        wait_for_out_valid(seen);
        if (!timed_out && seen != last_accept + 2) begin
            other_errors++;
            $display("out_valid rose %0d edges after the fourth sample instead of 2",
                     seen - last_accept);
        end
        wait_for_drain();
    endtask

    // Adjacent samples never form a carry chain longer than four bits
    task automatic exact_short_chains();
        avg_pkg::sample_t vals [12];
        vals = '{8'h10, 8'h21, 8'h55, 8'hAA, 8'h33, 8'h44,
                 8'h0F, 8'h01, 8'h55, 8'h55, 8'h02, 8'h08};
        foreach (vals[i]) begin
            drive_sample(vals[i]);
            check_avg(last_model, last_exact, "short-chain mean");
        end
        idle_cycles(1);
        wait_for_drain();
    endtask

    task automatic approx_long_chains();
        drive_sample(8'h7F);
        drive_sample(8'h01);
        drive_sample(8'h7F);
        drive_sample(8'h01);
        if (last_model === last_exact) begin
            other_errors++;
            $display("approximate mean of 7F and 01 pairs matched the exact mean");
        end
        drive_sample(8'h1F);
        drive_sample(8'h01);
        drive_sample(8'h1F);
        drive_sample(8'h01);
        if (last_model === last_exact) begin
            other_errors++;
            $display("approximate mean of 1F and 01 pairs matched the exact mean");
        end
        idle_cycles(1);
        wait_for_drain();
    endtask

    task automatic back_to_back_stream();
        repeat (8) begin
            drive_sample(avg_pkg::sample_t'($random(seed)));
        end
        idle_cycles(1);
        wait_for_drain();
    endtask

    task automatic sparse_strobes();
        for (int i = 0; i < 6; i++) begin
            drive_sample(avg_pkg::sample_t'($random(seed)));
            idle_cycles(3 + i % 3);
        end
        wait_for_drain();
    endtask

    task automatic random_stream();
        int gap;
        repeat (200) begin
            drive_sample(avg_pkg::sample_t'($random(seed)));
            gap = $unsigned($random(seed)) % 4;
            idle_cycles(gap);
        end
        idle_cycles(1);
        wait_for_drain();
    endtask

    // ********************
    // Main sequence
    // ********************
    initial begin
        seed = 32'hd29437dc;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_sample = '0;
        cycle_cnt = 0;
        fill_cnt = 0;
        last_accept = 0;
        value_errors = 0;
        valid_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;
        foreach (taps[i]) begin
            taps[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        fill_latency();
        if (!timed_out) begin
            exact_short_chains();
        end
        if (!timed_out) begin
            approx_long_chains();
        end
        if (!timed_out) begin
            back_to_back_stream();
        end
        if (!timed_out) begin
            sparse_strobes();
        end
        if (!timed_out) begin
            random_stream();
        end

        $display("errors: value %0d, valid %0d, other %0d, timeout %0d",
                 value_errors, valid_errors, other_errors, timed_out);
        if (value_errors + valid_errors + other_errors == 0 && !timed_out) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- rtl/approx_avg_top.sv
`timescale 1ns/1ps

module approx_avg_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  avg_pkg::sample_t in_sample,
    output logic             out_valid,
    output avg_pkg::sample_t out_avg
);

    avg_pkg::window_t   win;
    logic               win_valid;
    avg_pkg::pair_bus_t pairs;
    logic               pairs_valid;

    // ********************
    // Pipeline stages
    // ********************
    // Sample window, updated on each strobe
    window_stage u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .win       (win),
        .win_valid (win_valid)
    );

    // Approximate pair sums
    pair_sum_stage u_pair_sum (
        .clk         (clk),
        .rst_n       (rst_n),
        .win         (win),
        .win_valid   (win_valid),
        .pairs       (pairs),
        .pairs_valid (pairs_valid)
    );

    // Exact total and divide by four
    average_stage u_average (
        .clk         (clk),
        .rst_n       (rst_n),
        .pairs       (pairs),
        .pairs_valid (pairs_valid),
        .out_avg     (out_avg),
        .out_valid   (out_valid)
    );

endmodule

//--- rtl/average_stage.sv
`timescale 1ns/1ps

module average_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  avg_pkg::pair_bus_t pairs,
    input  logic               pairs_valid,
    output avg_pkg::sample_t   out_avg,
    output logic               out_valid
);

    avg_pkg::total_t total;

    // ********************
    // Exact final sum
    // ********************
    // Both pair sums widen to the total width before adding
    assign total = avg_pkg::total_t'(pairs.p_new) + avg_pkg::total_t'(pairs.p_old);

    // Divide by four, truncating the two low bits
    always_ff @(posedge clk) begin
        if (pairs_valid) begin
            out_avg <= total[9:2];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pairs_valid;
        end
    end

endmodule

//--- rtl/pair_sum_stage.sv
`timescale 1ns/1ps

module pair_sum_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  avg_pkg::window_t   win,
    input  logic               win_valid,
    output avg_pkg::pair_bus_t pairs,
    output logic               pairs_valid
);

    avg_pkg::pair_sum_t sum_new;
    avg_pkg::pair_sum_t sum_old;

    // ********************
    // Approximate pair adders
    // ********************
    // Two newest taps
    gda_adder u_add_new (
        .in1 (win.s0),
        .in2 (win.s1),
        .res (sum_new)
    );

    // Two oldest taps
    gda_adder u_add_old (
        .in1 (win.s2),
        .in2 (win.s3),
        .res (sum_old)
    );

    // ********************
    // Stage register
    // ********************
    always_ff @(posedge clk) begin
        if (win_valid) begin
            pairs.p_new <= sum_new;
            pairs.p_old <= sum_old;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pairs_valid <= 1'b0;
        end else begin
            pairs_valid <= win_valid;
        end
    end

endmodule

//--- rtl/window_stage.sv
`timescale 1ns/1ps
`include "avg_cfg.svh"

module window_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  avg_pkg::sample_t in_sample,
    output avg_pkg::window_t win,
    output logic             win_valid
);

    localparam int CNT_W = $clog2(`AVG_TAPS + 1);
    localparam logic [CNT_W-1:0] TAPS = CNT_W'(`AVG_TAPS);

    logic [CNT_W-1:0] fill_cnt;
    logic [CNT_W-1:0] fill_next;
    logic             win_full;

    // ********************
    // Fill tracking
    // ********************
    // Saturates once the window holds a full set of taps
    always_comb begin
        fill_next = fill_cnt;
        if (in_valid && (fill_cnt != TAPS)) begin
            fill_next = fill_cnt + 1'b1;
        end
    end

    // Includes the sample being accepted this cycle
    assign win_full = (fill_next == TAPS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt  <= '0;
            win_valid <= 1'b0;
        end else begin
            fill_cnt  <= fill_next;
            win_valid <= in_valid && win_full;
        end
    end

    // ********************
    // Sample window
    // ********************
    // Shift only on a strobe, idle cycles hold the taps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win <= '0;
        end else if (in_valid) begin
            win.s0 <= in_sample;
            win.s1 <= win.s0;
            win.s2 <= win.s1;
            win.s3 <= win.s2;
        end
    end

endmodule

//--- rtl/gda_adder.sv
`timescale 1ns/1ps
`include "avg_cfg.svh"

module gda_adder (
    input  avg_pkg::sample_t   in1,
    input  avg_pkg::sample_t   in2,
    output avg_pkg::pair_sum_t res
);

    wire [7:0] gen;
    wire [7:0] prop;
    wire [7:1] carry;
    wire [8:0] sum_bits;
    wire       p7c7;

    genvar i;
    genvar k;
    genvar d;

    // ********************
    // Generate and propagate
    // ********************
    generate
        for (i = 0; i < 8; i = i + 1) begin : g_gp
            and u_gen (gen[i], in1[i], in2[i]);
            xor u_prop (prop[i], in1[i], in2[i]);
        end
    endgenerate

    // ********************
    // Windowed carry prediction
    // ********************
    // Carry into bit k only looks back over the last GDA_WINDOW positions.
    // Lower bits have fewer positions below them, so the depth shrinks there.
    generate
        for (k = 1; k < 8; k = k + 1) begin : g_carry
            localparam int DEPTH = (k < `GDA_WINDOW) ? k : `GDA_WINDOW;

            // Propagate product of bits k-d up to k-1
            wire [DEPTH-1:0] run;
            // Generate at bit k-1-d carried through to bit k
            wire [DEPTH-1:0] term;
            // OR of the terms seen so far
            wire [DEPTH-1:0] acc;

            // Nothing lies between bit k-1 and bit k
            assign run[0] = 1'b1;
            and u_term0 (term[0], gen[k-1], run[0]);
            assign acc[0] = term[0];

            for (d = 1; d < DEPTH; d = d + 1) begin : g_tap
                and u_run (run[d], run[d-1], prop[k-d]);
                and u_term (term[d], gen[k-1-d], run[d]);
                or  u_acc (acc[d], acc[d-1], term[d]);
            end

            assign carry[k] = acc[DEPTH-1];
        end
    endgenerate

    // ********************
    // Sum and carry out
    // ********************
    assign sum_bits[0] = prop[0];

    generate
        for (i = 1; i < 8; i = i + 1) begin : g_sum
            xor u_sum (sum_bits[i], prop[i], carry[i]);
        end
    endgenerate

    // Full carry out of the top bit from its own generate and predicted carry in
    and u_p7c7 (p7c7, prop[7], carry[7]);
    or  u_cout (sum_bits[8], gen[7], p7c7);

    assign res = sum_bits;

endmodule

//--- rtl/avg_pkg.sv
package avg_pkg;

    // ********************
    // Data widths
    // ********************

    // One unsigned input or output sample
    typedef logic [7:0] sample_t;

    // Sum of two samples with its carry out
    typedef logic [8:0] pair_sum_t;

    // Sum of all four taps
    typedef logic [9:0] total_t;

    // ********************
    // Pipeline buses
    // ********************

    // Sample window, s0 newest and s3 oldest
    typedef struct packed {
        sample_t s0;
        sample_t s1;
        sample_t s2;
        sample_t s3;
    } window_t;

    // Pair sums, p_new is s0 plus s1 and p_old is s2 plus s3
    typedef struct packed {
        pair_sum_t p_new;
        pair_sum_t p_old;
    } pair_bus_t;

endpackage

//--- rtl/avg_cfg.svh
`ifndef AVG_CFG_SVH
`define AVG_CFG_SVH

// Lower bit positions whose generate terms may set a predicted carry
// Valid range is 1 to 7, a value of 7 gives the exact sum
`define GDA_WINDOW 4

// Samples the window must receive before it holds a full set of taps
`define AVG_TAPS 4

`endif
